/* Bender.yml */
package:
  name: dot_engine

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dnn_pkg.sv
      - hdl/macc.sv
      - hdl/dot_sequencer.sv
      - hdl/activation.sv
      - hdl/dot_engine.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/dot_checker.sv
      - bench/tb_dot_engine.sv

/* bench/dot_checker.sv */
`timescale 1ns/1ps
`include "dnn_settings.svh"

module dot_checker (
	input logic                                 clk,
	input logic                                 reset,
	input logic                                 start,
	input dnn_pkg::run_mode_e                   mode,
	input logic [`DOT_LEN_WIDTH-1:0]            length,
	input logic                                 relu,
	input logic                                 in_valid,
	input logic [`DOT_LANES*`PRECISION_OP-1:0]  op_a,
	input logic [`DOT_LANES*`PRECISION_OP-1:0]  op_b,
	input logic [`DOT_LANES*`PRECISION_ACC-1:0] bias,
	input logic                                 busy,
	input logic                                 result_valid,
	input logic [`DOT_LANES*`PRECISION_OP-1:0]  result
);
	import dnn_pkg::*;

	localparam int LANES = `DOT_LANES;
	localparam int W     = `PRECISION_OP;
	localparam int AW    = `PRECISION_ACC;
	localparam int F     = `PRECISION_FRAC;

	int value_errors  = 0;
	int strobe_errors = 0;
	int results_seen  = 0;

	logic               busy_m;
	logic               next_busy;
	logic               relu_m;
	run_mode_e          mode_m;
	int                 len_m;
	int                 count_m;
	int                 due; // Edges left until the result strobe, 0 when none is owed
	logic [W-1:0]       r_m [LANES];
	logic [LANES*W-1:0] exp_result;
	logic [W-1:0]       got;
	logic [W-1:0]       want;

	// Lane register after one element, kept to W bits so that it wraps
	function automatic logic [W-1:0] lane_update(input run_mode_e m, input logic first,
		input logic signed [W-1:0] a, input logic signed [W-1:0] b,
		input logic signed [AW-1:0] lane_bias, input logic signed [W-1:0] r);
		logic signed [AW-1:0] x;
		logic signed [AW-1:0] y;
		logic signed [AW-1:0] base;
		logic signed [AW-1:0] sum;
		x = a;
		y = (m == mode_sum_sq) ? a : b;
		if (!first)
			base = r; // Running sum, sign-extended
		else if (m == mode_dot_bias)
			base = lane_bias;
		else
			base = '0;
		sum = x * y + (base <<< F);
		return sum[W-1:0];
	endfunction

	function automatic logic [W-1:0] lane_result(input logic signed [W-1:0] r, input logic rect);
		logic signed [W-1:0] shifted;
		shifted = r >>> F;
		if (rect && shifted[W-1])
			shifted = '0;
		return shifted;
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			busy_m  = 1'b0;
			due     = 0;
			count_m = 0;
			len_m   = 0;
		end else begin
			next_busy = busy_m;
			if (busy !== busy_m) begin
				$display("Error: busy got %h expected %h at %0t", busy, busy_m, $time);
				value_errors++;
			end
			if (due == 1) begin
				if (result_valid !== 1'b1) begin
					$display("result_valid did not pulse four cycles after the last element at %0t",
						$time);
					strobe_errors++;
				end else begin
					results_seen++;
					for (int i = 0; i < LANES; i++) begin
						got  = result[i*W +: W];
						want = exp_result[i*W +: W];
						if (got !== want) begin
							$display("Error: result lane %0d got %h expected %h at %0t",
								i, got, want, $time);
							value_errors++;
						end
					end
				end
			end else if (result_valid !== 1'b0) begin
				$display("result_valid pulsed with no run finishing at %0t", $time);
				strobe_errors++;
			end
			if (due != 0)
				due--;
			if (busy_m && in_valid && count_m < len_m) begin
				for (int i = 0; i < LANES; i++)
					r_m[i] = lane_update(mode_m, count_m == 0, op_a[i*W +: W], op_b[i*W +: W],
						bias[i*AW +: AW], r_m[i]);
				count_m++;
				if (count_m == len_m) begin
					for (int i = 0; i < LANES; i++)
						exp_result[i*W +: W] = lane_result(r_m[i], relu_m);
					due = 4;
				end
			end
			if (start && !busy_m) begin
				mode_m    = mode;
				len_m     = length;
				relu_m    = relu;
				count_m   = 0;
				next_busy = 1'b1;
			end
			if (due == 1)
				next_busy = 1'b0; // Busy falls together with the result strobe
			busy_m = next_busy;
		end
	end

endmodule

/* bench/tb_dot_engine.sv */
`timescale 1ns/1ps
`include "dnn_settings.svh"

module tb_dot_engine;
	import dnn_pkg::*;

	localparam int RUNS  = 200;
	localparam int LANES = `DOT_LANES;
	localparam int W     = `PRECISION_OP;
	localparam int AW    = `PRECISION_ACC;

	// Longest run is every element followed by a gap, plus start, latency and idle time
	localparam int TIMEOUT_CYCLES = RUNS * (2 * `DOT_MAX_LEN + 12) + 1200;

	logic                      clk;
	logic                      reset;
	logic                      start;
	run_mode_e                 mode;
	logic [`DOT_LEN_WIDTH-1:0] length;
	logic                      relu;
	logic                      in_valid;
	logic [LANES*W-1:0]        op_a;
	logic [LANES*W-1:0]        op_b;
	logic [LANES*AW-1:0]       bias;
	logic                      busy;
	logic                      result_valid;
	logic [LANES*W-1:0]        result;

	logic [31:0] lfsr;
	int          cycles;
	int          extra_errors;

	dot_engine uut (
		.clk          (clk),
		.reset        (reset),
		.start        (start),
		.mode         (mode),
		.length       (length),
		.relu         (relu),
		.in_valid     (in_valid),
		.op_a         (op_a),
		.op_b         (op_b),
		.bias         (bias),
		.busy         (busy),
		.result_valid (result_valid),
		.result       (result)
	);

	dot_checker u_check (
		.clk          (clk),
		.reset        (reset),
		.start        (start),
		.mode         (mode),
		.length       (length),
		.relu         (relu),
		.in_valid     (in_valid),
		.op_a         (op_a),
		.op_b         (op_b),
		.bias         (bias),
		.busy         (busy),
		.result_valid (result_valid),
		.result       (result)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit handed out
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	function automatic logic random_bit();
		logic [31:0] v;
		v = random_bits(1);
		return v[0];
	endfunction

	function automatic run_mode_e pick_mode();
		logic [31:0] v;
		v = random_bits(2);
		if (v[1:0] == 2'd3)
			return mode_dot; // The unused code folds back onto a plain dot product
		return run_mode_e'(v[1:0]);
	endfunction

	task automatic randomize_operands();
		logic [LANES*W-1:0] a;
		logic [LANES*W-1:0] b;
		logic [31:0]        word;
		for (int i = 0; i < LANES; i++) begin
			word = random_bits(W);
			a[i*W +: W] = word[W-1:0];
			word = random_bits(W);
			b[i*W +: W] = word[W-1:0];
		end
		op_a <= a;
		op_b <= b;
	endtask

	task automatic randomize_bias();
		logic [LANES*AW-1:0] v;
		for (int i = 0; i < LANES; i++)
			v[i*AW +: AW] = random_bits(AW);
		bias <= v;
	endtask

	// Idle time between runs, with stray elements that the engine must ignore
	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			start    <= 1'b0;
			in_valid <= random_bit();
			randomize_operands();
		end
	endtask

	// Start a run and stream its elements, leaving the bus three cycles past the last one
	task automatic issue_run();
		logic [31:0]               v;
		logic [`DOT_LEN_WIDTH-1:0] len;
		v   = random_bits(4);
		len = v[3:0] + 1'b1;
		@(posedge clk);
		start    <= 1'b1;
		mode     <= pick_mode();
		length   <= len;
		relu     <= random_bit();
		in_valid <= random_bit(); // Dropped in the start cycle
		randomize_bias();
		randomize_operands();
		for (int e = 0; e < len; e++) begin
			@(posedge clk);
			if (random_bits(2) == 3) begin
				start    <= random_bit(); // Busy, so this start is dropped
				mode     <= pick_mode();
				v        = random_bits(`DOT_LEN_WIDTH);
				length   <= v[`DOT_LEN_WIDTH-1:0];
				relu     <= random_bit();
				in_valid <= 1'b0;
				randomize_operands();
				@(posedge clk);
			end
			start    <= 1'b0;
			in_valid <= 1'b1;
			randomize_operands();
		end
		repeat (3) begin
			@(posedge clk);
			start    <= 1'b0;
			in_valid <= random_bit(); // Past the length, so nothing is accumulated
			randomize_operands();
		end
	endtask

	task automatic wait_result();
		do begin
			@(posedge clk);
			start    <= 1'b0;
			in_valid <= random_bit();
		end while (result_valid !== 1'b1);
	endtask

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		logic chain;
		int   total;
		lfsr         = 32'h4eff;
		extra_errors = 0;
		reset        = 1'b1;
		start        = 1'b0;
		mode         = mode_dot;
		length       = '0;
		relu         = 1'b0;
		in_valid     = 1'b0;
		op_a         = '0;
		op_b         = '0;
		bias         = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		idle_cycles(6);
		for (int run = 0; run < RUNS; run++) begin
			// A chained run starts in the very cycle the previous result appears
			chain = (run < RUNS - 1) && (random_bits(2) == 0);
			issue_run();
			if (!chain) begin
				wait_result();
				idle_cycles(random_bits(2));
			end
		end
		idle_cycles(6);
		if (u_check.results_seen != RUNS) begin
			$display("Only %0d results were seen for %0d runs", u_check.results_seen, RUNS);
			extra_errors++;
		end
		total = u_check.value_errors + u_check.strobe_errors + extra_errors;
		$display("Errors: value %0d, strobe %0d, other %0d, total %0d",
			u_check.value_errors, u_check.strobe_errors, extra_errors, total);
		if (total == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* hdl/activation.sv */
`timescale 1ns/1ps
`include "dnn_settings.svh"

module activation #(
	parameter int LANES = `DOT_LANES,
	parameter int WIDTH = `PRECISION_OP
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start,
	input  logic                   relu,
	input  logic                   done,
	input  logic [LANES*WIDTH-1:0] lanes_in,
	output logic                   result_valid,
	output logic [LANES*WIDTH-1:0] result
);

	logic                   relu_q;
	logic [LANES*WIDTH-1:0] rectified;

	// Relu belongs to the run, so it is taken when the run is accepted
	always_ff @(posedge clk) begin
		if (reset)
			relu_q <= 1'b0;
		else if (start)
			relu_q <= relu;
	end

	always_comb begin
		rectified = lanes_in;
		for (int i = 0; i < LANES; i++) begin
			// Negative lanes go to zero when the rectifier is on
			if (relu_q && lanes_in[i*WIDTH + WIDTH - 1])
				rectified[i*WIDTH +: WIDTH] = '0;
		end
	end

	// Result holds until the next run finishes
	always_ff @(posedge clk) begin
		if (done)
			result <= rectified;
	end

	always_ff @(posedge clk) begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= done;
	end

endmodule

/* hdl/dnn_pkg.sv */
package dnn_pkg;

	// Addend selected for the final add of a lane
	typedef enum logic [1:0] {
		acc_none       = 2'd0, // Product alone
		acc_accumulate = 2'd1, // Product plus the lane's own register
		acc_add        = 2'd2  // Product plus the lane's bias
	} acc_mode_e;

	// Operation code as issued by the sequencer (raw) and as decoded by a lane (fields)
	// Raw encoding: 0 mul, 1 square, 2 mul-acc, 3 square-acc, 4 mul-add, 5 square-add
	typedef union packed {
		logic [2:0] raw;
		struct packed {
			acc_mode_e acc_mode; // Bits 2:1
			logic      square;   // Bit 0, op_0 is used for both factors
		} fields;
	} op_code_u;

	// Kind of run requested by the host
	typedef enum logic [1:0] {
		mode_dot      = 2'd0,
		mode_dot_bias = 2'd1,
		mode_sum_sq   = 2'd2
	} run_mode_e;

endpackage

/* hdl/dnn_settings.svh */
`ifndef DNN_SETTINGS_SVH
`define DNN_SETTINGS_SVH

// Fixed-point format of the operands and of each lane result
`define PRECISION_OP   16
`define PRECISION_FRAC 8

// Width of a product and of the per-lane bias word
`define PRECISION_ACC  32

// One lane per output neuron
`define DOT_LANES      4

// Longest vector a single run may stream in
`define DOT_MAX_LEN    16

// Length port is wide enough to hold DOT_MAX_LEN itself
`define DOT_LEN_WIDTH  5

`endif

/* hdl/dot_engine.sv */
`timescale 1ns/1ps
`include "dnn_settings.svh"

module dot_engine (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   start,
	input  dnn_pkg::run_mode_e                     mode,
	input  logic [`DOT_LEN_WIDTH-1:0]              length,
	input  logic                                   relu,
	input  logic                                   in_valid,
	input  logic [`DOT_LANES*`PRECISION_OP-1:0]    op_a,
	input  logic [`DOT_LANES*`PRECISION_OP-1:0]    op_b,
	input  logic [`DOT_LANES*`PRECISION_ACC-1:0]   bias,
	output logic                                   busy,
	output logic                                   result_valid,
	output logic [`DOT_LANES*`PRECISION_OP-1:0]    result
);
	import dnn_pkg::*;

	logic                                enable;
	logic                                clear;
	logic                                done;
	op_code_u                            op_code;
	logic [`DOT_LANES*`PRECISION_OP-1:0] lane_out; // Lane i in slice i

	dot_sequencer u_sequencer (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.mode     (mode),
		.length   (length),
		.in_valid (in_valid),
		.busy     (busy),
		.enable   (enable),
		.clear    (clear),
		.op_code  (op_code),
		.done     (done)
	);

	// All lanes share the control; each gets its own operands and bias
	for (genvar i = 0; i < `DOT_LANES; i++) begin : g_lane
		macc #(
			.OP_WIDTH  (`PRECISION_OP),
			.ACC_WIDTH (`PRECISION_ACC),
			.OUT_WIDTH (`PRECISION_OP),
			.FRAC_BITS (`PRECISION_FRAC)
		) u_macc (
			.clk     (clk),
			.reset   (reset),
			.enable  (enable),
			.clear   (clear),
			.op_code (op_code),
			.op_0    (op_a[i*`PRECISION_OP +: `PRECISION_OP]),
			.op_1    (op_b[i*`PRECISION_OP +: `PRECISION_OP]),
			.op_add  (bias[i*`PRECISION_ACC +: `PRECISION_ACC]),
			.out     (lane_out[i*`PRECISION_OP +: `PRECISION_OP])
		);
	end

	activation #(
		.LANES (`DOT_LANES),
		.WIDTH (`PRECISION_OP)
	) u_activation (
		.clk          (clk),
		.reset        (reset),
		.start        (clear), // Clear marks an accepted start, so a dropped start keeps relu
		.relu         (relu),
		.done         (done),
		.lanes_in     (lane_out),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

/* hdl/dot_sequencer.sv */
`timescale 1ns/1ps
`include "dnn_settings.svh"

module dot_sequencer (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      start,
	input  dnn_pkg::run_mode_e        mode,
	input  logic [`DOT_LEN_WIDTH-1:0] length,
	input  logic                      in_valid,
	output logic                      busy,
	output logic                      enable,
	output logic                      clear,
	output dnn_pkg::op_code_u         op_code,
	output logic                      done
);
	import dnn_pkg::*;

	// Raw operation codes, in the encoding the lanes decode
	localparam logic [2:0] OP_MUL        = 3'd0;
	localparam logic [2:0] OP_SQUARE     = 3'd1;
	localparam logic [2:0] OP_MUL_ACC    = 3'd2;
	localparam logic [2:0] OP_SQUARE_ACC = 3'd3;
	localparam logic [2:0] OP_MUL_ADD    = 3'd4;

	logic                      accept;
	logic                      first;
	logic                      last;
	logic                      last_d1;
	logic                      last_d2;
	logic                      pending; // Elements of the run still to come
	logic [`DOT_LEN_WIDTH-1:0] count;
	logic [`DOT_LEN_WIDTH-1:0] length_q;
	run_mode_e                 mode_q;

	// A start while a run is in progress is dropped
	assign accept = start & ~busy;

	// The lanes flush their register two cycles after this, ahead of the first element
	assign clear = accept;

	assign pending = (count != length_q);

	// Elements beyond the latched length are not passed on
	assign enable = in_valid & busy & pending;

	assign first = (count == '0);

	assign last = enable & (count == length_q - 1'b1);

	always_ff @(posedge clk) begin
		if (reset) begin
			mode_q   <= mode_dot;
			length_q <= '0;
		end else if (accept) begin
			mode_q   <= mode;
			length_q <= length;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			count <= '0;
		else if (accept)
			count <= '0; // Restart the element count for the new run
		else if (enable)
			count <= count + 1'b1;
	end

	// First element starts the sum, later ones accumulate
	always_comb begin
		case (mode_q)
			mode_dot_bias: op_code.raw = first ? OP_MUL_ADD : OP_MUL_ACC;
			mode_sum_sq:   op_code.raw = first ? OP_SQUARE : OP_SQUARE_ACC;
			default:       op_code.raw = first ? OP_MUL : OP_MUL_ACC;
		endcase
	end

	// The last marker follows the element through the three lane stages
	always_ff @(posedge clk) begin
		if (reset) begin
			last_d1 <= 1'b0;
			last_d2 <= 1'b0;
			done    <= 1'b0;
		end else begin
			last_d1 <= last;
			last_d2 <= last_d1;
			done    <= last_d2;
		end
	end

	// Busy drops together with the result strobe, so the host may start again in that cycle
	always_ff @(posedge clk) begin
		if (reset)
			busy <= 1'b0;
		else if (accept)
			busy <= 1'b1;
		else if (done)
			busy <= 1'b0;
	end

endmodule

/* hdl/macc.sv */
`timescale 1ns/1ps
`include "dnn_settings.svh"

module macc #(
	parameter int OP_WIDTH  = `PRECISION_OP,
	parameter int ACC_WIDTH = `PRECISION_ACC,
	parameter int OUT_WIDTH = `PRECISION_OP,
	parameter int FRAC_BITS = `PRECISION_FRAC
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        enable,
	input  logic                        clear,
	input  dnn_pkg::op_code_u           op_code,
	input  logic signed [OP_WIDTH-1:0]  op_0,
	input  logic signed [OP_WIDTH-1:0]  op_1,
	input  logic signed [ACC_WIDTH-1:0] op_add,
	output logic signed [OUT_WIDTH-1:0] out
);
	import dnn_pkg::*;

	localparam int PROD_WIDTH = 2 * OP_WIDTH;

	// Stage one, registered inputs
	logic signed [OP_WIDTH-1:0]  op_0_d;
	logic signed [OP_WIDTH-1:0]  op_1_d;
	logic signed [ACC_WIDTH-1:0] op_add_d;
	op_code_u                    op_code_d;
	logic                        enable_d;
	logic                        clear_d;

	// Stage two, product
	logic signed [PROD_WIDTH-1:0] full_product;
	logic signed [ACC_WIDTH-1:0]  product;
	logic signed [ACC_WIDTH-1:0]  op_add_dd;
	op_code_u                     op_code_dd;
	logic                         enable_dd;
	logic                         clear_dd;

	// Stage three, the lane register
	logic signed [ACC_WIDTH-1:0] addend;
	logic signed [ACC_WIDTH-1:0] sum;
	logic signed [OUT_WIDTH-1:0] r_reg;

	always_ff @(posedge clk) begin
		if (enable) begin
			op_0_d   <= op_0;
			op_1_d   <= op_code.fields.square ? op_0 : op_1; // Square ignores op_1
			op_add_d <= op_add;
		end else begin
			op_0_d   <= '0; // An idle slot carries zeros down the pipe
			op_1_d   <= '0;
			op_add_d <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_code_d <= '0;
			enable_d  <= 1'b0;
			clear_d   <= 1'b0;
		end else begin
			op_code_d <= op_code;
			enable_d  <= enable;
			clear_d   <= clear;
		end
	end

	assign full_product = op_0_d * op_1_d;

	always_ff @(posedge clk) begin
		if (enable_d)
			product <= ACC_WIDTH'(full_product);
		else
			product <= '0;
		op_add_dd <= op_add_d;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_code_dd <= '0;
			enable_dd  <= 1'b0;
			clear_dd   <= 1'b0;
		end else begin
			op_code_dd <= op_code_d;
			enable_dd  <= enable_d;
			clear_dd   <= clear_d;
		end
	end

	// The addend lives in the same fixed-point scale as the output
	always_comb begin
		case (op_code_dd.fields.acc_mode)
			acc_accumulate: addend = ACC_WIDTH'(r_reg); // Sign-extended running sum
			acc_add:        addend = op_add_dd;
			default:        addend = '0;
		endcase
	end

	assign sum = product + (addend <<< FRAC_BITS);

	// Only the low OUT_WIDTH bits are kept, so the running sum wraps
	always_ff @(posedge clk) begin
		if (reset || clear_dd)
			r_reg <= '0; // Clear wins over a coinciding update
		else if (enable_dd)
			r_reg <= sum[OUT_WIDTH-1:0];
	end

	assign out = r_reg >>> FRAC_BITS;

endmodule

/* tb.f */
+incdir+hdl
hdl/dnn_pkg.sv
hdl/macc.sv
hdl/dot_sequencer.sv
hdl/activation.sv
hdl/dot_engine.sv
bench/dot_checker.sv
bench/tb_dot_engine.sv
